//--- hw/audio_capture_settings.svh
/*
 * audio capture settings
 * widths, I2S timing, metering block length and LED bar thresholds
 */

`ifndef AUDIO_CAPTURE_SETTINGS_SVH
`define AUDIO_CAPTURE_SETTINGS_SVH

// ----------------------------------------
// sample format
// ----------------------------------------
// signed two's-complement word from the microphone
`define SAMPLE_W 24

// ----------------------------------------
// I2S timing
// ----------------------------------------
// bit-clock periods in one channel slot
`define SLOT_BITS 32
// system clocks per sck half period
`define SCK_HALF 4

// ----------------------------------------
// level meter
// ----------------------------------------
// frames per metering window
`define BLOCK_FRAMES 256
// number of bar LEDs
`define LED_COUNT 6
// lowest LED threshold is 2**LED_BASE_BIT
`define LED_BASE_BIT 17

`endif

//--- hw/audio_capture_pkg.sv
/*
 * audio capture types
 * sample, stereo frame, I2S clock pair and LED bar definitions
 */

`include "audio_capture_settings.svh"

package audio_capture_pkg;

    // ----------------------------------------
    // audio data
    // ----------------------------------------
    // one microphone sample, signed
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // absolute value, sign bit dropped
    // most negative input saturates to all ones
    typedef logic [`SAMPLE_W-2:0] magnitude_t;

    // one stereo frame, left in the upper half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } audio_frame_t;

    // ----------------------------------------
    // I2S clocks
    // ----------------------------------------
    // ws low selects left, high selects right
    typedef struct packed {
        logic sck;
        logic ws;
    } i2s_bus_t;

    // ----------------------------------------
    // LED bar
    // ----------------------------------------
    // active low, a 0 lights the LED
    typedef logic [`LED_COUNT-1:0] led_bar_t;

endpackage

//--- hw/i2s_clock_gen.sv
/*
 * I2S master clock generator
 * divides the system clock down to sck and flips ws
 * on a falling sck edge once per channel slot
 */

`timescale 1ns/1ps

`include "audio_capture_settings.svh"

module i2s_clock_gen import audio_capture_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    output i2s_bus_t bus_o
);

    localparam int HALF_W = $clog2(`SCK_HALF);
    localparam int BIT_W  = $clog2(`SLOT_BITS);

    // system clocks within the current sck half
    logic [HALF_W-1:0] half_cnt;
    // sck periods within the current slot
    logic [BIT_W-1:0]  bit_cnt;
    logic              sck_q;
    logic              ws_q;
    logic              half_done;
    logic              slot_done;

    assign half_done = (half_cnt == HALF_W'(`SCK_HALF - 1));
    // last period of the slot
    assign slot_done = (bit_cnt == BIT_W'(`SLOT_BITS - 1));

    // ----------------------------------------
    // sck and ws generation
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            half_cnt <= '0;
            bit_cnt  <= '0;
            sck_q    <= 1'b0;
            ws_q     <= 1'b0;
        end else if (half_done) begin
            half_cnt <= '0;
            sck_q    <= ~sck_q;
            // sck high now, so this toggle is a falling edge
            if (sck_q) begin
                if (slot_done) begin
                    bit_cnt <= '0;
                    // ws moves together with the falling edge
                    ws_q    <= ~ws_q;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // straight from flops, no glitches on the pins
    assign bus_o.sck = sck_q;
    assign bus_o.ws  = ws_q;

endmodule

//--- hw/i2s_receiver.sv
/*
 * I2S receiver
 * samples sd on rising sck edges, keeps the first 24 bits
 * of each slot after the one-bit delay and emits a stereo
 * frame with a one-cycle strobe when the right word completes
 */

`timescale 1ns/1ps

`include "audio_capture_settings.svh"

module i2s_receiver import audio_capture_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  i2s_bus_t     bus_i,
    input  logic         sd_i,
    output audio_frame_t frame_o,
    output logic         frame_valid_o
);

    localparam int CNT_W = $clog2(`SAMPLE_W + 1);

    // sck one clock ago, for edge detection
    logic                 sck_q;
    // ws as seen at the previous rising sck edge
    logic                 ws_q;
    logic                 sck_rise;
    logic                 slot_start;
    logic                 shift_en;
    logic                 word_done;
    // data bits taken in this slot, parks at SAMPLE_W
    logic [CNT_W-1:0]     bit_cnt;
    logic [`SAMPLE_W-2:0] shift_q;
    sample_t              word;
    sample_t              left_hold;
    // set at the first left slot after reset
    logic                 armed;

    // ----------------------------------------
    // edge and slot detection
    // ----------------------------------------
    assign sck_rise   = bus_i.sck & ~sck_q;
    // first rising edge after a ws change carries the delay bit
    assign slot_start = sck_rise & (bus_i.ws != ws_q);
    // data bits follow until the word is full
    assign shift_en   = sck_rise & ~slot_start & (bit_cnt != CNT_W'(`SAMPLE_W));
    // this edge delivers the LSB
    assign word_done  = shift_en & (bit_cnt == CNT_W'(`SAMPLE_W - 1));
    // word including the bit on the line right now
    assign word       = {shift_q, sd_i};

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sck_q         <= 1'b0;
            ws_q          <= 1'b0;
            // idle until a real slot start is seen
            bit_cnt       <= CNT_W'(`SAMPLE_W);
            armed         <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            sck_q         <= bus_i.sck;
            frame_valid_o <= 1'b0;
            if (sck_rise) begin
                ws_q <= bus_i.ws;
            end
            if (slot_start) begin
                bit_cnt <= '0;
                // ws fell, a full left slot begins here
                if (!bus_i.ws) begin
                    armed <= 1'b1;
                end
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // right word closes the frame
            if (word_done && bus_i.ws && armed) begin
                frame_valid_o <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // data path
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (shift_en) begin
            shift_q <= word[`SAMPLE_W-2:0];
        end
        // left word waits for its right partner
        if (word_done && !bus_i.ws) begin
            left_hold <= word;
        end
        if (word_done && bus_i.ws) begin
            frame_o.left  <= left_hold;
            frame_o.right <= word;
        end
    end

endmodule

//--- hw/peak_tracker.sv
/*
 * peak tracker
 * running maximum of one channel's sample magnitude,
 * cleared at the end of each metering block
 */

`timescale 1ns/1ps

`include "audio_capture_settings.svh"

module peak_tracker import audio_capture_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  sample_t    sample_i,
    input  logic       sample_valid_i,
    input  logic       block_end_i,
    output magnitude_t peak_o
);

    // -2**(SAMPLE_W-1) has no positive counterpart
    localparam sample_t MOST_NEG = {1'b1, {(`SAMPLE_W - 1){1'b0}}};

    sample_t    neg_sample;
    magnitude_t magnitude;

    // ----------------------------------------
    // absolute value
    // ----------------------------------------
    always_comb begin
        neg_sample = -sample_i;
        if (sample_i == MOST_NEG) begin
            // saturate to full scale
            magnitude = '1;
        end else if (sample_i[`SAMPLE_W-1]) begin
            magnitude = neg_sample[`SAMPLE_W-2:0];
        end else begin
            magnitude = sample_i[`SAMPLE_W-2:0];
        end
    end

    // ----------------------------------------
    // running maximum
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            peak_o <= '0;
        end else if (block_end_i) begin
            // new block starts from silence
            peak_o <= '0;
        end else if (sample_valid_i && (magnitude > peak_o)) begin
            peak_o <= magnitude;
        end
    end

endmodule

//--- hw/vu_led_bar.sv
/*
 * level bar driver
 * counts frames per metering block, takes the louder
 * channel peak at block end and shows it as an active-low
 * thermometer in 6 dB steps
 */

`timescale 1ns/1ps

`include "audio_capture_settings.svh"

module vu_led_bar import audio_capture_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       frame_valid_i,
    input  magnitude_t left_peak_i,
    input  magnitude_t right_peak_i,
    output logic       block_end_o,
    output led_bar_t   leds_o
);

    localparam int CNT_W = $clog2(`BLOCK_FRAMES);

    // frames seen in the current block
    logic [CNT_W-1:0] frame_cnt;
    logic             last_frame;
    magnitude_t       loud_peak;
    led_bar_t         bar_next;

    assign last_frame = (frame_cnt == CNT_W'(`BLOCK_FRAMES - 1));

    // ----------------------------------------
    // block counter
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            frame_cnt   <= '0;
            block_end_o <= 1'b0;
        end else begin
            block_end_o <= 1'b0;
            if (frame_valid_i) begin
                if (last_frame) begin
                    // wrap, next frame opens a new block
                    frame_cnt   <= '0;
                    block_end_o <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // louder channel and thermometer code
    // ----------------------------------------
    assign loud_peak = (left_peak_i > right_peak_i) ? left_peak_i : right_peak_i;

    always_comb begin
        for (int n = 0; n < `LED_COUNT; n++) begin
            // LED n at 2**(base+n), 0 means lit
            bar_next[n] = ~(loud_peak >= (magnitude_t'(1) << (`LED_BASE_BIT + n)));
        end
    end

    // ----------------------------------------
    // bar register
    // ----------------------------------------
    // peaks already hold the last frame when block_end is high,
    // trackers clear in the same clock
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // all dark
            leds_o <= '1;
        end else if (block_end_o) begin
            leds_o <= bar_next;
        end
    end

endmodule

//--- hw/audio_capture_top.sv
/*
 * stereo I2S microphone front end
 * clock generator, receiver, left and right peak trackers
 * and a six-LED level bar
 */

`timescale 1ns/1ps

module audio_capture_top import audio_capture_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         i2s_sd_i,
    output logic         i2s_sck_o,
    output logic         i2s_ws_o,
    output audio_frame_t frame_o,
    output logic         frame_valid_o,
    output led_bar_t     debug_led_o
);

    // ----------------------------------------
    // internal wiring
    // ----------------------------------------
    i2s_bus_t     bus;
    audio_frame_t frame;
    logic         frame_valid;
    // one-cycle pulse after the last frame of a block
    logic         block_end;
    magnitude_t   left_peak;
    magnitude_t   right_peak;

    // clock pair to the microphone
    assign i2s_sck_o     = bus.sck;
    assign i2s_ws_o      = bus.ws;
    // capture visible at the pins
    assign frame_o       = frame;
    assign frame_valid_o = frame_valid;

    // ----------------------------------------
    // I2S clocks and capture
    // ----------------------------------------
    i2s_clock_gen u_clock (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .bus_o   (bus)
    );

    i2s_receiver u_receiver (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .bus_i         (bus),
        .sd_i          (i2s_sd_i),
        .frame_o       (frame),
        .frame_valid_o (frame_valid)
    );

    // ----------------------------------------
    // per-channel peaks
    // ----------------------------------------
    peak_tracker u_peak_left (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_i       (frame.left),
        .sample_valid_i (frame_valid),
        .block_end_i    (block_end),
        .peak_o         (left_peak)
    );

    peak_tracker u_peak_right (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .sample_i       (frame.right),
        .sample_valid_i (frame_valid),
        .block_end_i    (block_end),
        .peak_o         (right_peak)
    );

    // block timing and bar
    vu_led_bar u_led_bar (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .frame_valid_i (frame_valid),
        .left_peak_i   (left_peak),
        .right_peak_i  (right_peak),
        .block_end_o   (block_end),
        .leds_o        (debug_led_o)
    );

endmodule

//--- verification/audio_capture_tb.sv
/*
 * testbench for the stereo I2S microphone front end
 * models the microphone, checks captured frames, the I2S
 * clock shape and the LED bar over four metering blocks
 */

`timescale 1ns/1ps

`include "audio_capture_settings.svh"

module audio_capture_tb import audio_capture_pkg::*; ();

    // one stereo frame in system clocks
    localparam int FRAME_CLOCKS  = 2 * `SLOT_BITS * 2 * `SCK_HALF;
    localparam int FRAME_TIMEOUT = 4 * FRAME_CLOCKS;
    localparam int BLOCKS        = 4;
    localparam led_bar_t DARK    = '1;
    localparam sample_t MOST_NEG = {1'b1, {(`SAMPLE_W - 1){1'b0}}};

    logic         clk = 1'b0;
    logic         reset_i;
    logic         i2s_sd_i = 1'b0;
    logic         i2s_sck_o;
    logic         i2s_ws_o;
    audio_frame_t frame_o;
    logic         frame_valid_o;
    led_bar_t     debug_led_o;

    // frames sent by the microphone model in order
    audio_frame_t frame_q[$];
    int           frames_made = 0;
    // right shift per block
    // last entry covers frames past the run
    int           shift_tbl[$];
    led_bar_t     exp_leds = '1;
    magnitude_t   block_max;

    // microphone model state
    logic         mic_sck = 1'b0;
    logic         mic_ws = 1'b0;
    int           slot_pos = `SLOT_BITS;
    bit           have_left = 1'b0;
    sample_t      left_word;
    sample_t      slot_word;
    sample_t      out_word;
    audio_frame_t pending;

    // clock shape monitor state
    logic         mon_sck = 1'b0;
    logic         mon_ws = 1'b0;
    int           half_clocks = -1;
    int           sck_periods = 0;

    audio_capture_top UUT (
        .clk_i         (clk),
        .reset_i       (reset_i),
        .i2s_sd_i      (i2s_sd_i),
        .i2s_sck_o     (i2s_sck_o),
        .i2s_ws_o      (i2s_ws_o),
        .frame_o       (frame_o),
        .frame_valid_o (frame_valid_o),
        .debug_led_o   (debug_led_o)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // random sample for frame idx scaled by its block shift
    function automatic sample_t make_sample(int idx, bit right);
        int      blk;
        sample_t s;
        blk = idx / `BLOCK_FRAMES;
        if (blk > BLOCKS) begin
            blk = BLOCKS;
        end
        s = sample_t'($urandom);
        s = s >>> shift_tbl[blk];
        // full scale negative once in block 1 and once in block 3
        if ((idx == `BLOCK_FRAMES + 100 && !right) ||
            (idx == 3 * `BLOCK_FRAMES + 37 && right)) begin
            s = MOST_NEG;
        end
        return s;
    endfunction

    // absolute value where most negative clips to full scale
    function automatic magnitude_t magnitude_of(sample_t s);
        if (s == MOST_NEG) begin
            return '1;
        end
        if (s[`SAMPLE_W-1]) begin
            return magnitude_t'(-s);
        end
        return magnitude_t'(s);
    endfunction

    // thresholds rise in 6 dB steps so lit LEDs are always the low ones
    function automatic led_bar_t bar_for(magnitude_t peak);
        int lit;
        lit = 0;
        for (int n = 0; n < `LED_COUNT; n++) begin
            if (int'(peak) >= (1 << (`LED_BASE_BIT + n))) begin
                lit++;
            end
        end
        return DARK << lit;
    endfunction

    // ----------------------------------------
    // checks and waits
    // ----------------------------------------
    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_frame(audio_frame_t expected);
        if (frame_o !== expected) begin
            abort_run($sformatf("Error: frame_o expected %h got %h", expected, frame_o));
        end
    endtask

    task automatic check_leds(led_bar_t expected);
        if (debug_led_o !== expected) begin
            abort_run($sformatf("Error: debug_led_o expected %h got %h",
                                expected, debug_led_o));
        end
    endtask

    // single-bit output that must be low
    task automatic expect_low(string name, logic actual);
        if (actual !== 1'b0) begin
            abort_run($sformatf("Error: %s expected %h got %h", name, 1'b0, actual));
        end
    endtask

    // returns once outputs have settled after the edge
    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    // next frame strobe while the bar holds
    task automatic wait_frame();
        int cycles;
        cycles = 0;
        do begin
            step_clock();
            check_leds(exp_leds);
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                abort_run("timeout while waiting for frame_valid_o");
            end
        end while (frame_valid_o !== 1'b1);
    endtask

    // ----------------------------------------
    // microphone model
    // ----------------------------------------
    // drives sd on falling sck with the delay bit before the MSB
    always @(posedge clk) begin
        #1;
        if (!reset_i && mic_sck && !i2s_sck_o) begin
            if (i2s_ws_o != mic_ws) begin
                slot_pos = 0;
                if (!i2s_ws_o) begin
                    // left slot opens a frame
                    left_word = make_sample(frames_made, 1'b0);
                    have_left = 1'b1;
                    slot_word = left_word;
                end else begin
                    slot_word = make_sample(frames_made, 1'b1);
                    // right slot before any left one is never captured
                    if (have_left) begin
                        pending.left  = left_word;
                        pending.right = slot_word;
                        frame_q.push_back(pending);
                        frames_made++;
                    end
                end
                out_word = slot_word;
            end else if (slot_pos < `SLOT_BITS) begin
                slot_pos++;
            end
            if (slot_pos >= 1 && slot_pos <= `SAMPLE_W) begin
                i2s_sd_i = out_word[`SAMPLE_W-1];
                out_word = out_word << 1;
            end else begin
                // delay bit and slot tail
                i2s_sd_i = 1'b0;
            end
        end
        mic_sck = i2s_sck_o;
        mic_ws  = i2s_ws_o;
    end

    // ----------------------------------------
    // I2S clock shape
    // ----------------------------------------
    always @(posedge clk) begin
        #1;
        if (reset_i) begin
            half_clocks = -1;
            sck_periods = 0;
        end else begin
            if (half_clocks >= 0) begin
                half_clocks++;
            end
            if (i2s_sck_o !== mon_sck) begin
                // first toggle only syncs the count
                if (half_clocks >= 0 && half_clocks != `SCK_HALF) begin
                    abort_run("sck half period is not 4 system clocks");
                end
                half_clocks = 0;
                if (!i2s_sck_o) begin
                    sck_periods++;
                end
            end
            if (i2s_ws_o !== mon_ws) begin
                if (!(mon_sck && !i2s_sck_o)) begin
                    abort_run("ws changed away from a falling sck edge");
                end
                if (sck_periods != `SLOT_BITS) begin
                    abort_run("ws slot is not 32 sck periods long");
                end
                sck_periods = 0;
            end
        end
        mon_sck = i2s_sck_o;
        mon_ws  = i2s_ws_o;
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        audio_frame_t expected;
        reset_i = 1'b1;
        void'($urandom(32'hf0b3));
        shift_tbl.push_back($urandom % 8);
        shift_tbl.push_back($urandom % 8);
        // quiet block right after the loud one
        shift_tbl.push_back(7);
        shift_tbl.push_back($urandom % 8);
        shift_tbl.push_back(0);

        repeat (5) begin
            step_clock();
            check_leds(DARK);
            expect_low("frame_valid_o", frame_valid_o);
            expect_low("i2s_sck_o", i2s_sck_o);
            expect_low("i2s_ws_o", i2s_ws_o);
        end
        reset_i   = 1'b0;
        block_max = '0;

        for (int blk = 0; blk < BLOCKS; blk++) begin
            for (int f = 0; f < `BLOCK_FRAMES; f++) begin
                wait_frame();
                if (frame_q.size() == 0) begin
                    abort_run("frame_valid_o pulsed with no frame sent");
                end
                expected = frame_q.pop_front();
                check_frame(expected);
                if (magnitude_of(expected.left) > block_max) begin
                    block_max = magnitude_of(expected.left);
                end
                if (magnitude_of(expected.right) > block_max) begin
                    block_max = magnitude_of(expected.right);
                end
            end
            // bar moves two clocks after the last strobe
            step_clock();
            check_leds(exp_leds);
            expect_low("frame_valid_o", frame_valid_o);
            step_clock();
            exp_leds = bar_for(block_max);
            check_leds(exp_leds);
            block_max = '0;
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- audio_capture_top.f
+incdir+hw
hw/audio_capture_pkg.sv
hw/i2s_clock_gen.sv
hw/i2s_receiver.sv
hw/peak_tracker.sv
hw/vu_led_bar.sv
hw/audio_capture_top.sv
verification/audio_capture_tb.sv

//--- Makefile
# Verilator build and run of the audio capture testbench

TB  := audio_capture_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TB) -f audio_capture_top.f
	./obj_dir/V$(TB) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
